/* rx_mac_consts.svh */
`ifndef RX_MAC_CONSTS_SVH
`define RX_MAC_CONSTS_SVH

`default_nettype none

// frame buffer geometry
`define RX_ADDR_W 9
`define RX_DEPTH 512

// destination accepted by every station
`define RX_BCAST_ADDR 8'h2a

// crc-8 generator x^8+x^2+x+1, msb first
`define RX_CRC_POLY 8'h07

`default_nettype wire

`endif

/* rx_mac_pkg.sv */
`default_nettype none

package rx_mac_pkg;

    // values carried in the third frame byte
    typedef enum logic [7:0] {
        // plain data, fcs ignored
        FT_DATA        = 8'd0,
        // data, fcs must be good
        FT_DATA_FCS    = 8'd1,
        // data that asks the sender for an ack
        FT_DATA_ACKREQ = 8'd2,
        // ack from the far end, never delivered
        FT_ACK         = 8'd3
    } frame_type_e;

endpackage

`default_nettype wire

/* rx_buf_if.sv */
`include "rx_mac_consts.svh"
`timescale 1ns/1ns
`default_nettype none

interface rx_buf_if;

    // write port
    logic                  write_en;
    logic [`RX_ADDR_W-1:0] write_address;
    logic [7:0]            write_data;

    // registered read port
    logic                  read_en;
    logic [`RX_ADDR_W-1:0] read_address;
    logic [7:0]            read_data;

    modport ctrl (
        output write_en, write_address, write_data,
        output read_en, read_address,
        input  read_data
    );

    modport mem (
        input  write_en, write_address, write_data,
        input  read_en, read_address,
        output read_data
    );

endinterface

`default_nettype wire

/* rx_frame_buffer.sv */
`include "rx_mac_consts.svh"
`timescale 1ns/1ns
`default_nettype none

module rx_frame_buffer (
    input logic   clk,
    rx_buf_if.mem fbuf
);

    logic [7:0] mem [`RX_DEPTH];

    always_ff @(posedge clk) begin
        if (fbuf.write_en) begin
            mem[fbuf.write_address] <= fbuf.write_data;
        end
    end

    // read register only moves on a read, so a shown byte stays put
    always_ff @(posedge clk) begin
        if (fbuf.read_en) begin
            fbuf.read_data <= mem[fbuf.read_address];
        end
    end

endmodule

`default_nettype wire

/* rx_fcs_check.sv */
`include "rx_mac_consts.svh"
`timescale 1ns/1ns
`default_nettype none

module rx_fcs_check (
    input  logic       clk,
    input  logic       rst,
    input  logic       clear,
    input  logic       byte_valid,
    input  logic [7:0] byte_data,
    output logic [7:0] fcs
);

    logic [7:0] base;

    // one byte folded in, msb first, eight shift steps unrolled
    function automatic logic [7:0] crc8_step(input logic [7:0] crc, input logic [7:0] d);
        logic [7:0] c;
        logic       fb;
        c = crc;
        for (int i = 7; i >= 0; i--) begin
            fb = c[7] ^ d[i];
            c  = {c[6:0], 1'b0};
            if (fb) begin
                c = c ^ `RX_CRC_POLY;
            end
        end
        return c;
    endfunction

    // clear and first byte may land in the same cycle
    assign base = clear ? 8'h00 : fcs;

    always_ff @(posedge clk) begin
        if (rst) begin
            fcs <= 8'h00;
        end else if (byte_valid) begin
            fcs <= crc8_step(base, byte_data);
        end else begin
            fcs <= base;
        end
    end

endmodule

`default_nettype wire

/* rcv_controller.sv */
`include "rx_mac_consts.svh"
`timescale 1ns/1ns
`default_nettype none

module rcv_controller
    import rx_mac_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       valid,
    input  logic       cardet,
    input  logic       rrdy,
    input  logic [7:0] data_rcvr,
    input  logic [7:0] mac,
    rx_buf_if.ctrl     fbuf,
    input  logic [7:0] fcs,
    output logic       crc_clear,
    output logic       crc_valid,
    output logic [7:0] crc_data,
    output logic       rvalid,
    output logic       ack_needed,
    output logic       ack_received,
    output logic [7:0] rdata,
    output logic [7:0] rerrcount
);

    typedef enum logic [2:0] {IDLE, WRITE, TYPE_REQ, TYPE_DEC, LOAD, SHOW} state_t;

    localparam logic [`RX_ADDR_W:0]   DEPTH     = (`RX_ADDR_W+1)'(`RX_DEPTH);
    localparam logic [`RX_ADDR_W:0]   MIN_LEN   = (`RX_ADDR_W+1)'(4);
    localparam logic [`RX_ADDR_W-1:0] TYPE_ADDR = (`RX_ADDR_W)'(2);

    state_t state, next;

    // stored byte count and delivery pointer, one bit wider than the address
    logic [`RX_ADDR_W:0] len;
    logic [`RX_ADDR_W:0] rd_ptr;

    logic        is_bcast;
    logic        skip;
    logic        addr_ok;
    logic        take_first;
    logic        take_byte;
    logic        store_byte;
    logic        fcs_good;
    logic        deliver;
    logic        rerr_inc;
    frame_type_e ftype;

    assign addr_ok    = (data_rcvr == mac) || (data_rcvr == `RX_BCAST_ADDR);
    assign take_first = (state == IDLE) && valid && cardet && !skip && addr_ok;
    assign take_byte  = (state == WRITE) && valid && cardet;
    // bytes past the end of the buffer still go through the crc
    assign store_byte = take_byte && (len != DEPTH);
    assign fcs_good   = (fcs == 8'h00);
    assign ftype      = frame_type_e'(fbuf.read_data);

    // type rules, read_data holds the type byte in TYPE_DEC
    always_comb begin
        deliver      = 1'b0;
        rerr_inc     = 1'b0;
        ack_needed   = 1'b0;
        ack_received = 1'b0;
        if (state == TYPE_DEC && len >= MIN_LEN) begin
            case (ftype)
                FT_DATA: deliver = 1'b1;
                FT_DATA_FCS: begin
                    if (fcs_good) begin
                        deliver = 1'b1;
                    end else begin
                        rerr_inc = 1'b1;
                    end
                end
                FT_DATA_ACKREQ: begin
                    if (fcs_good) begin
                        deliver    = 1'b1;
                        ack_needed = !is_bcast;
                    end else begin
                        rerr_inc = 1'b1;
                    end
                end
                FT_ACK: begin
                    if (fcs_good) begin
                        ack_received = 1'b1;
                    end else begin
                        rerr_inc = 1'b1;
                    end
                end
                // unknown types are dropped quietly
                default: ;
            endcase
        end
    end

    always_comb begin
        next = state;
        case (state)
            IDLE:     if (take_first) next = WRITE;
            WRITE:    if (!cardet) next = TYPE_REQ;
            TYPE_REQ: next = TYPE_DEC;
            TYPE_DEC: next = deliver ? LOAD : IDLE;
            LOAD:     next = SHOW;
            SHOW: begin
                if (rrdy) begin
                    next = (rd_ptr + 1'b1 == len) ? IDLE : LOAD;
                end
            end
            default:  next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            len       <= '0;
            rd_ptr    <= '0;
            is_bcast  <= 1'b0;
            rerrcount <= 8'h00;
        end else begin
            state <= next;
            if (take_first) begin
                len      <= (`RX_ADDR_W+1)'(1);
                is_bcast <= (data_rcvr == `RX_BCAST_ADDR);
            end else if (store_byte) begin
                len <= len + 1'b1;
            end
            if (state == TYPE_DEC) begin
                rd_ptr <= '0;
            end else if (state == SHOW && rrdy) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (rerr_inc) begin
                rerrcount <= rerrcount + 8'h01;
            end
        end
    end

    // ignore the rest of a frame that was rejected or began while busy
    always_ff @(posedge clk) begin
        if (rst || !cardet) begin
            skip <= 1'b0;
        end else if (state != IDLE && state != WRITE) begin
            skip <= 1'b1;
        end else if (state == IDLE && valid && !addr_ok) begin
            skip <= 1'b1;
        end
    end

    assign fbuf.write_en      = take_first || store_byte;
    assign fbuf.write_address = take_first ? '0 : len[`RX_ADDR_W-1:0];
    assign fbuf.write_data    = data_rcvr;
    assign fbuf.read_en       = (state == TYPE_REQ) || (state == LOAD);
    assign fbuf.read_address  = (state == TYPE_REQ) ? TYPE_ADDR : rd_ptr[`RX_ADDR_W-1:0];

    assign crc_clear = (state == IDLE);
    assign crc_valid = take_first || take_byte;
    assign crc_data  = data_rcvr;

    assign rvalid = (state == SHOW);
    assign rdata  = fbuf.read_data;

endmodule

`default_nettype wire

/* rx_mac_top.sv */
`timescale 1ns/1ns
`default_nettype none

module rx_mac_top (
    input  logic       clk,
    input  logic       rst,
    input  logic       valid,
    input  logic       cardet,
    input  logic [7:0] data_rcvr,
    input  logic [7:0] mac,
    input  logic       rrdy,
    output logic       rvalid,
    output logic [7:0] rdata,
    output logic       ack_needed,
    output logic       ack_received,
    output logic [7:0] rerrcount
);

    logic       crc_clear;
    logic       crc_valid;
    logic [7:0] crc_data;
    logic [7:0] fcs;

    rx_buf_if bus0 ();

    rcv_controller u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .valid        (valid),
        .cardet       (cardet),
        .rrdy         (rrdy),
        .data_rcvr    (data_rcvr),
        .mac          (mac),
        .fbuf         (bus0.ctrl),
        .fcs          (fcs),
        .crc_clear    (crc_clear),
        .crc_valid    (crc_valid),
        .crc_data     (crc_data),
        .rvalid       (rvalid),
        .ack_needed   (ack_needed),
        .ack_received (ack_received),
        .rdata        (rdata),
        .rerrcount    (rerrcount)
    );

    rx_frame_buffer u_buf (
        .clk  (clk),
        .fbuf (bus0.mem)
    );

    rx_fcs_check u_fcs (
        .clk        (clk),
        .rst        (rst),
        .clear      (crc_clear),
        .byte_valid (crc_valid),
        .byte_data  (crc_data),
        .fcs        (fcs)
    );

endmodule

`default_nettype wire

/* rx_mac_properties.sv */
`timescale 1ns/1ns
`default_nettype none

module rx_mac_properties (
    input logic       clk,
    input logic       rst,
    input logic       cardet,
    input logic       rrdy,
    input logic       rvalid,
    input logic [7:0] rdata,
    input logic       ack_needed,
    input logic       ack_received,
    input logic       write_en
);

    // set by the first stored byte, held until carrier drops
    logic storing;

    always_ff @(posedge clk) begin
        if (rst || !cardet) begin
            storing <= 1'b0;
        end else if (write_en) begin
            storing <= 1'b1;
        end
    end

    // a shown byte waits for the consumer
    hold_while_stalled: assert property (
        @(posedge clk) disable iff (rst)
        (rvalid && !rrdy) |=> (rvalid && $stable(rdata))
    ) else $error("rvalid or rdata moved while rrdy was low");

    ack_needed_one_cycle: assert property (
        @(posedge clk) disable iff (rst)
        ack_needed |=> !ack_needed
    ) else $error("ack_needed high for two cycles in a row");

    ack_received_one_cycle: assert property (
        @(posedge clk) disable iff (rst)
        ack_received |=> !ack_received
    ) else $error("ack_received high for two cycles in a row");

    // outputs stay quiet in reset and one cycle beyond
    quiet_around_reset: assert property (
        @(posedge clk)
        (rst || $past(rst)) |-> !(rvalid || ack_needed || ack_received)
    ) else $error("output active during or right after reset");

    no_delivery_while_storing: assert property (
        @(posedge clk) disable iff (rst)
        (cardet && (storing || write_en)) |-> !rvalid
    ) else $error("rvalid high while a frame is being stored");

endmodule

bind rx_mac_top rx_mac_properties props0 (
    .clk          (clk),
    .rst          (rst),
    .cardet       (cardet),
    .rrdy         (rrdy),
    .rvalid       (rvalid),
    .rdata        (rdata),
    .ack_needed   (ack_needed),
    .ack_received (ack_received),
    .write_en     (bus0.write_en)
);

`default_nettype wire

/* rx_mac_tb.sv */
`include "rx_mac_consts.svh"
`timescale 1ns/1ns
`default_nettype none

module rx_mac_tb
    import rx_mac_pkg::*;
();

    localparam logic [7:0] MAC            = 8'h5c;
    localparam logic [7:0] SRC            = 8'h71;
    localparam int         DELIVERY_LIMIT = 4000;

    logic       clk;
    logic       rst;
    logic       valid;
    logic       cardet;
    logic [7:0] data_rcvr;
    logic [7:0] mac;
    logic       rrdy;
    logic       rvalid;
    logic [7:0] rdata;
    logic       ack_needed;
    logic       ack_received;
    logic [7:0] rerrcount;

    integer     seed;
    logic [7:0] frame[$];
    logic [7:0] got[$];
    logic [7:0] err_model;
    int         ackn_model;
    int         ackr_model;
    int         ackn_seen;
    int         ackr_seen;

    rx_mac_top dut0 (
        .clk          (clk),
        .rst          (rst),
        .valid        (valid),
        .cardet       (cardet),
        .data_rcvr    (data_rcvr),
        .mac          (mac),
        .rrdy         (rrdy),
        .rvalid       (rvalid),
        .rdata        (rdata),
        .ack_needed   (ack_needed),
        .ack_received (ack_received),
        .rerrcount    (rerrcount)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // mid-cycle sampling of transfers and ack pulses
    always @(negedge clk) begin
        if (rvalid && rrdy) got.push_back(rdata);
        if (ack_needed) ackn_seen++;
        if (ack_received) ackr_seen++;
    end

    // crc-8 over the first n frame bytes, xor the byte in then shift
    function automatic logic [7:0] crc8_over(input int n);
        logic [7:0] r;
        r = 8'h00;
        for (int k = 0; k < n; k++) begin
            r = r ^ frame[k];
            repeat (8) r = r[7] ? ((r << 1) ^ `RX_CRC_POLY) : (r << 1);
        end
        return r;
    endfunction

    task automatic check_value(input string name, input string what,
                               input int expected, input int actual);
        assert (expected == actual) else begin
            $display("Error: %s %s expected %0h actual %0h", name, what, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic make_frame(input logic [7:0] dst, input logic [7:0] ftype,
                              input int n_payload, input bit bad_fcs);
        logic [7:0] fcs_byte;
        frame = {};
        frame.push_back(dst);
        frame.push_back(SRC);
        frame.push_back(ftype);
        for (int i = 0; i < n_payload; i++) begin
            frame.push_back(8'($random(seed)));
        end
        fcs_byte = crc8_over(frame.size());
        if (bad_fcs) fcs_byte = fcs_byte ^ 8'h5a;
        frame.push_back(fcs_byte);
    endtask

    // one byte per cycle with short random gaps, then carrier drops
    task automatic send_frame();
        int gap;
        cardet = 1'b1;
        foreach (frame[k]) begin
            gap = $random(seed) & 3;
            valid = 1'b0;
            repeat (gap) begin
                @(posedge clk);
                #10;
            end
            valid     = 1'b1;
            data_rcvr = frame[k];
            @(posedge clk);
            #10;
        end
        valid  = 1'b0;
        cardet = 1'b0;
    endtask

    // random rrdy until n bytes are in and rvalid has gone quiet
    task automatic collect_bytes(input string name, input int n);
        int cycles;
        int quiet;
        cycles = 0;
        quiet  = 0;
        while ((got.size() < n || cycles < 8 || quiet < 4) && cycles < DELIVERY_LIMIT) begin
            @(posedge clk);
            #10;
            rrdy   = ($random(seed) & 3) != 0;
            quiet  = rvalid ? 0 : quiet + 1;
            cycles = cycles + 1;
        end
        rrdy = 1'b0;
        if (got.size() < n || quiet < 4) begin
            $display("Timeout: %s delivery still running after %0d cycles", name, cycles);
            $display("TEST FAIL");
            $fatal(1, "delivery timeout");
        end
    endtask

    task automatic run_frame(input string name);
        logic [7:0] ftype;
        bit         fcs_ok;
        bit         accept;
        bit         deliver;
        int         n_exp;
        ftype   = frame[2];
        fcs_ok  = (crc8_over(frame.size()) == 8'h00);
        accept  = (frame[0] == MAC || frame[0] == `RX_BCAST_ADDR) && frame.size() >= 4;
        deliver = 1'b0;
        if (accept) begin
            case (ftype)
                FT_DATA:     deliver = 1'b1;
                FT_DATA_FCS: deliver = fcs_ok;
                FT_DATA_ACKREQ: begin
                    deliver = fcs_ok;
                    if (fcs_ok && frame[0] != `RX_BCAST_ADDR) ackn_model++;
                end
                FT_ACK: if (fcs_ok) ackr_model++;
                default: ;
            endcase
            if (ftype >= 8'd1 && ftype <= 8'd3 && !fcs_ok) err_model = err_model + 8'd1;
        end
        n_exp = deliver ? frame.size() : 0;
        got   = {};
        send_frame();
        collect_bytes(name, n_exp);
        check_value(name, "byte count", n_exp, got.size());
        foreach (got[k]) begin
            check_value(name, $sformatf("byte %0d", k), frame[k], got[k]);
        end
        check_value(name, "rerrcount", err_model, rerrcount);
        check_value(name, "ack_needed pulses", ackn_model, ackn_seen);
        check_value(name, "ack_received pulses", ackr_model, ackr_seen);
    endtask

    initial begin
        seed       = 32'h2fa3_8aaf;
        rst        = 1'b1;
        valid      = 1'b0;
        cardet     = 1'b0;
        data_rcvr  = 8'h00;
        mac        = MAC;
        rrdy       = 1'b0;
        err_model  = 8'h00;
        ackn_model = 0;
        ackr_model = 0;
        ackn_seen  = 0;
        ackr_seen  = 0;
        repeat (10) @(posedge clk);
        #10;
        rst = 1'b0;

        // type 0 ignores the fcs
        make_frame(MAC, FT_DATA, 5, 1'b1);
        run_frame("type0_bad_fcs");

        make_frame(MAC, FT_DATA_FCS, 6, 1'b0);
        run_frame("type1_good");
        make_frame(MAC, FT_DATA_FCS, 6, 1'b1);
        run_frame("type1_bad");

        make_frame(MAC, FT_DATA_ACKREQ, 4, 1'b0);
        run_frame("type2_unicast");
        make_frame(`RX_BCAST_ADDR, FT_DATA_ACKREQ, 4, 1'b0);
        run_frame("type2_broadcast");
        make_frame(MAC, FT_DATA_ACKREQ, 4, 1'b1);
        run_frame("type2_bad");

        make_frame(MAC, FT_ACK, 0, 1'b0);
        run_frame("type3_good");
        make_frame(MAC, FT_ACK, 2, 1'b1);
        run_frame("type3_bad");

        // frames that must vanish without a trace
        make_frame(8'h13, FT_DATA_FCS, 3, 1'b0);
        run_frame("other_address");
        make_frame(MAC, 8'd7, 3, 1'b0);
        run_frame("unknown_type");
        make_frame(MAC, FT_DATA_FCS, 0, 1'b0);
        void'(frame.pop_back());
        run_frame("three_bytes");
        make_frame(MAC, FT_DATA_FCS, 3, 1'b0);
        run_frame("after_drops");

        // long frame under heavy rrdy stalls
        make_frame(`RX_BCAST_ADDR, FT_DATA_FCS, 40, 1'b0);
        run_frame("stalled_order");

        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+.
rx_mac_pkg.sv
rx_buf_if.sv
rx_frame_buffer.sv
rx_fcs_check.sv
rcv_controller.sv
rx_mac_top.sv
rx_mac_properties.sv
rx_mac_tb.sv

/* Makefile */
TOP  := rx_mac_tb
BIN  := obj_dir/V$(TOP)
SRCS := $(filter-out +%,$(shell cat compile.f))

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source, the header or the file list changes
$(BIN): compile.f rx_mac_consts.svh $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f compile.f -Mdir obj_dir

run: $(BIN)
	./$(BIN) | tee sim.log
	@if grep -q "TEST FAIL" sim.log; then exit 1; fi
	@grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log
